/* include/sd_adma_config.svh */
`ifndef SD_ADMA_CONFIG_SVH
`define SD_ADMA_CONFIG_SVH

// System bus widths
`define SD_ADMA_ADDR_W 32
`define SD_ADMA_DATA_W 32

// Word and beat counters, room for 65536 bytes as words
`define SD_ADMA_COUNT_W 17

// Beats per data burst and per descriptor fetch
`define SD_ADMA_BURST_BEATS 16
`define SD_ADMA_DESC_BEATS 2

// Byte step from one descriptor line to the next
`define SD_ADMA_DESC_STEP 8

// Descriptor act field codes
`define SD_ADMA_ACT_TRAN 2'b10
`define SD_ADMA_ACT_LINK 2'b11

// Bit positions in dma_interrupts
`define SD_ADMA_IRQ_COMPLETE 0
`define SD_ADMA_IRQ_ERROR 1

`endif

/* source/sd_adma_pkg.sv */
`include "sd_adma_config.svh"

package sd_adma_pkg;

  // One ADMA2 descriptor line
  // beats[0] is the first beat off the bus, beats[1] the second
  // The fields view overlays the same 64 bits:
  //   address in the upper word, then length and attributes
  typedef union packed {
    logic [`SD_ADMA_DESC_BEATS-1:0][`SD_ADMA_DATA_W-1:0] beats;
    struct packed {
      logic [`SD_ADMA_ADDR_W-1:0] address;
      // Zero here stands for 65536 bytes
      logic [15:0]                length;
      logic [9:0]                 reserved_hi;
      logic [1:0]                 act;
      logic                       reserved_lo;
      logic                       int_flag;
      logic                       end_flag;
      logic                       valid;
    } fields;
  } adma_descriptor_t;

endpackage

/* source/fill_monitor.sv */
`timescale 1ns/1ns
`include "sd_adma_config.svh"

module fill_monitor (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         is_we_en,
  input  logic                         fifo_reset,
  output logic [`SD_ADMA_COUNT_W-1:0]  fill_count
);

  logic [1:0] we_sync;
  logic       we_prev;
  logic       we_fall;

  // Serializer enable comes in through two flops
  always_ff @(posedge clock) begin
    if (!reset) begin
      we_sync <= '0;
      we_prev <= 1'b0;
    end else begin
      we_sync <= {we_sync[0], is_we_en};
      we_prev <= we_sync[1];
    end
  end

  // End of each enable pulse means one more word in the FIFO
  assign we_fall = we_prev && !we_sync[1];

  always_ff @(posedge clock) begin
    if (!reset || fifo_reset) begin
      fill_count <= '0;
    end else if (we_fall) begin
      fill_count <= fill_count + 1'b1;
    end
  end

endmodule

/* source/adma_sequencer.sv */
`timescale 1ns/1ns
`include "sd_adma_config.svh"

module adma_sequencer (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          dma_enable,
  input  logic                          direction_to_card,
  input  logic                          cmd_complete,
  input  logic                          data_present,
  input  logic [`SD_ADMA_ADDR_W-1:0]    descriptor_base,
  input  logic                          xfer_complete,
  input  logic                          block_gap_request,
  input  logic                          int_clear,
  input  sd_adma_pkg::adma_descriptor_t descriptor,
  input  logic                          read_busy,
  input  logic                          write_busy,
  output logic                          fetch_start,
  output logic                          read_start,
  output logic                          write_start,
  output logic [`SD_ADMA_ADDR_W-1:0]    pointer,
  output logic [`SD_ADMA_ADDR_W-1:0]    data_address,
  output logic [`SD_ADMA_COUNT_W-1:0]   word_total,
  output logic                          fifo_reset,
  output logic [1:0]                    dma_interrupts
);

  localparam int ADDR_W  = `SD_ADMA_ADDR_W;
  localparam int COUNT_W = `SD_ADMA_COUNT_W;
  localparam logic [ADDR_W-1:0]  DESC_STEP = ADDR_W'(`SD_ADMA_DESC_STEP);
  localparam logic [COUNT_W-1:0] WORDS_64K = COUNT_W'(65536 / 4);

  localparam logic [1:0] ST_STOP = 2'd0;
  localparam logic [1:0] ST_FDS  = 2'd1;
  localparam logic [1:0] ST_CADR = 2'd2;
  localparam logic [1:0] ST_TFR  = 2'd3;

  logic [1:0] state;
  logic       tfr_started;
  logic       tfr_done;
  logic       masters_idle;
  logic       stop_after;

  // A start pulse is one cycle ahead of the busy level it causes
  assign masters_idle = !(fetch_start || read_start || write_start) &&
                        !read_busy && !write_busy;
  assign stop_after   = descriptor.fields.end_flag || block_gap_request;

  //////////////////////////////
  // Descriptor FSM
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (!reset) begin
      state          <= ST_STOP;
      pointer        <= '0;
      fetch_start    <= 1'b0;
      read_start     <= 1'b0;
      write_start    <= 1'b0;
      fifo_reset     <= 1'b0;
      tfr_started    <= 1'b0;
      tfr_done       <= 1'b0;
      dma_interrupts <= '0;
    end else begin
      fetch_start <= 1'b0;
      read_start  <= 1'b0;
      write_start <= 1'b0;
      fifo_reset  <= 1'b0;
      case (state)
        ST_STOP: begin
          if (dma_enable && cmd_complete && data_present) begin
            pointer     <= descriptor_base;
            fetch_start <= 1'b1;
            state       <= ST_FDS;
          end
        end
        ST_FDS: begin
          if (masters_idle) begin
            if (descriptor.fields.valid) begin
              state <= ST_CADR;
            end else begin
              dma_interrupts[`SD_ADMA_IRQ_ERROR] <= 1'b1;
              state <= ST_STOP;
            end
          end
        end
        ST_CADR: begin
          if (descriptor.fields.act == `SD_ADMA_ACT_TRAN) begin
            tfr_started <= 1'b0;
            tfr_done    <= 1'b0;
            state       <= ST_TFR;
          end else if (descriptor.fields.act == `SD_ADMA_ACT_LINK) begin
            pointer     <= descriptor.fields.address;
            fetch_start <= 1'b1;
            state       <= ST_FDS;
          end else if (!descriptor.fields.end_flag) begin
            // Nop, move on to the next line
            pointer     <= pointer + DESC_STEP;
            fetch_start <= 1'b1;
            state       <= ST_FDS;
          end else if (xfer_complete) begin
            pointer <= pointer + DESC_STEP;
            dma_interrupts[`SD_ADMA_IRQ_COMPLETE] <= 1'b1;
            state <= ST_STOP;
          end
        end
        ST_TFR: begin
          if (!tfr_started) begin
            tfr_started <= 1'b1;
            fifo_reset  <= 1'b1;
            read_start  <= direction_to_card;
            write_start <= !direction_to_card;
          end else if (!tfr_done) begin
            if (masters_idle) begin
              tfr_done <= 1'b1;
              pointer  <= pointer + DESC_STEP;
            end
          end else if (!stop_after) begin
            fetch_start <= 1'b1;
            state       <= ST_FDS;
          end else if (xfer_complete) begin
            dma_interrupts[`SD_ADMA_IRQ_COMPLETE] <= 1'b1;
            state <= ST_STOP;
          end
        end
        default: state <= ST_STOP;
      endcase
      if (int_clear) begin
        dma_interrupts <= '0;
      end
    end
  end

  // Transfer parameters, loaded with the start pulse
  always_ff @(posedge clock) begin
    if (state == ST_TFR && !tfr_started) begin
      data_address <= descriptor.fields.address;
      if (descriptor.fields.length == 16'd0) begin
        word_total <= WORDS_64K;
      end else begin
        word_total <= COUNT_W'(descriptor.fields.length[15:2]);
      end
    end
  end

endmodule

/* source/axi_read_master.sv */
`timescale 1ns/1ns
`include "sd_adma_config.svh"

module axi_read_master (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          fetch_start,
  input  logic                          read_start,
  input  logic [`SD_ADMA_ADDR_W-1:0]    pointer,
  input  logic [`SD_ADMA_ADDR_W-1:0]    data_address,
  input  logic [`SD_ADMA_COUNT_W-1:0]   word_total,
  input  logic                          arready,
  input  logic [`SD_ADMA_DATA_W-1:0]    rdata,
  input  logic                          rvalid,
  input  logic                          rlast,
  output logic [`SD_ADMA_ADDR_W-1:0]    araddr,
  output logic [7:0]                    arlen,
  output logic [2:0]                    arsize,
  output logic [1:0]                    arburst,
  output logic                          arvalid,
  output logic                          rready,
  output logic                          read_busy,
  output sd_adma_pkg::adma_descriptor_t descriptor,
  output logic                          fifo_write,
  output logic [`SD_ADMA_DATA_W-1:0]    fifo_write_data
);

  localparam int ADDR_W  = `SD_ADMA_ADDR_W;
  localparam int COUNT_W = `SD_ADMA_COUNT_W;
  localparam logic [ADDR_W-1:0] BURST_STEP =
    ADDR_W'(`SD_ADMA_BURST_BEATS * `SD_ADMA_DATA_W / 8);

  logic               desc_mode;
  logic [ADDR_W-1:0]  addr_q;
  logic [COUNT_W-1:0] beats_total;
  logic [COUNT_W-1:0] beats_done;
  logic               beat_ok;

  assign beat_ok = rready && rvalid;
  assign araddr  = addr_q;
  assign arlen   = desc_mode ? 8'(`SD_ADMA_DESC_BEATS - 1) : 8'(`SD_ADMA_BURST_BEATS - 1);
  assign arsize  = 3'b010;
  assign arburst = 2'b01;

  //////////////////////////////
  // Burst control
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (!reset) begin
      arvalid    <= 1'b0;
      rready     <= 1'b0;
      read_busy  <= 1'b0;
      desc_mode  <= 1'b0;
      beats_done <= '0;
      fifo_write <= 1'b0;
    end else begin
      fifo_write <= 1'b0;
      if (!read_busy) begin
        if (fetch_start || read_start) begin
          desc_mode   <= fetch_start;
          addr_q      <= fetch_start ? pointer : data_address;
          beats_total <= fetch_start ? COUNT_W'(`SD_ADMA_DESC_BEATS) : word_total;
          beats_done  <= '0;
          arvalid     <= 1'b1;
          read_busy   <= 1'b1;
        end
      end else begin
        if (arvalid && arready) begin
          arvalid <= 1'b0;
          rready  <= 1'b1;
          addr_q  <= addr_q + BURST_STEP;
        end
        if (beat_ok) begin
          beats_done <= beats_done + 1'b1;
          fifo_write <= !desc_mode;
          if (rlast) begin
            rready <= 1'b0;
            // More bursts until every word has arrived
            if (beats_done + 1'b1 >= beats_total) begin
              read_busy <= 1'b0;
            end else begin
              arvalid <= 1'b1;
            end
          end
        end
      end
    end
  end

  // Beat capture, first beat ends up in beats[0]
  always_ff @(posedge clock) begin
    if (beat_ok) begin
      if (desc_mode) begin
        descriptor.beats[1] <= rdata;
        descriptor.beats[0] <= descriptor.beats[1];
      end else begin
        fifo_write_data <= rdata;
      end
    end
  end

endmodule

/* source/axi_write_master.sv */
`timescale 1ns/1ns
`include "sd_adma_config.svh"

module axi_write_master (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         write_start,
  input  logic [`SD_ADMA_ADDR_W-1:0]   data_address,
  input  logic [`SD_ADMA_COUNT_W-1:0]  word_total,
  input  logic [`SD_ADMA_COUNT_W-1:0]  fill_count,
  input  logic                         awready,
  input  logic                         wready,
  input  logic [`SD_ADMA_DATA_W-1:0]   fifo_read_data,
  output logic [`SD_ADMA_ADDR_W-1:0]   awaddr,
  output logic [7:0]                   awlen,
  output logic [2:0]                   awsize,
  output logic [1:0]                   awburst,
  output logic                         awvalid,
  output logic [`SD_ADMA_DATA_W-1:0]   wdata,
  output logic                         wvalid,
  output logic                         wlast,
  output logic                         fifo_read,
  output logic                         write_busy
);

  localparam int ADDR_W  = `SD_ADMA_ADDR_W;
  localparam int COUNT_W = `SD_ADMA_COUNT_W;
  localparam int IDX_W   = $clog2(`SD_ADMA_BURST_BEATS);
  localparam logic [IDX_W-1:0]   LAST_IDX    = IDX_W'(`SD_ADMA_BURST_BEATS - 1);
  localparam logic [COUNT_W-1:0] BURST_WORDS = COUNT_W'(`SD_ADMA_BURST_BEATS);
  localparam logic [ADDR_W-1:0]  BURST_STEP  =
    ADDR_W'(`SD_ADMA_BURST_BEATS * `SD_ADMA_DATA_W / 8);

  logic [ADDR_W-1:0]  addr_q;
  logic [COUNT_W-1:0] total_q;
  logic [COUNT_W-1:0] sent_q;
  logic [IDX_W-1:0]   beat_idx;
  logic               beat_ok;
  logic               burst_ready;

  assign beat_ok   = wvalid && wready;
  assign fifo_read = beat_ok;
  assign wlast     = wvalid && (beat_idx == LAST_IDX);
  assign wdata     = fifo_read_data;
  assign awaddr    = addr_q;
  assign awlen     = 8'(`SD_ADMA_BURST_BEATS - 1);
  assign awsize    = 3'b010;
  assign awburst   = 2'b01;

  // Next burst only once the card has put a whole burst in the FIFO
  assign burst_ready = fill_count >= sent_q + BURST_WORDS;

  //////////////////////////////
  // Burst control
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (!reset) begin
      write_busy <= 1'b0;
      awvalid    <= 1'b0;
      wvalid     <= 1'b0;
      sent_q     <= '0;
      beat_idx   <= '0;
    end else if (!write_busy) begin
      if (write_start) begin
        addr_q     <= data_address;
        total_q    <= word_total;
        sent_q     <= '0;
        beat_idx   <= '0;
        write_busy <= 1'b1;
      end
    end else begin
      if (!awvalid && !wvalid && burst_ready) begin
        awvalid <= 1'b1;
      end
      if (awvalid && awready) begin
        awvalid <= 1'b0;
        wvalid  <= 1'b1;
        addr_q  <= addr_q + BURST_STEP;
      end
      if (beat_ok) begin
        sent_q   <= sent_q + 1'b1;
        beat_idx <= beat_idx + 1'b1;
        if (wlast) begin
          wvalid   <= 1'b0;
          beat_idx <= '0;
          if (sent_q + 1'b1 >= total_q) begin
            write_busy <= 1'b0;
          end
        end
      end
    end
  end

endmodule

/* source/sd_adma_top.sv */
`timescale 1ns/1ns
`include "sd_adma_config.svh"

module sd_adma_top (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        dma_enable,
  input  logic                        direction_to_card,
  input  logic                        cmd_complete,
  input  logic                        data_present,
  input  logic [`SD_ADMA_ADDR_W-1:0]  descriptor_base,
  input  logic                        xfer_complete,
  input  logic                        block_gap_request,
  input  logic                        int_clear,
  input  logic                        is_we_en,
  output logic [1:0]                  dma_interrupts,
  output logic                        fifo_reset,
  output logic                        fifo_write,
  output logic [`SD_ADMA_DATA_W-1:0]  fifo_write_data,
  output logic                        fifo_read,
  input  logic [`SD_ADMA_DATA_W-1:0]  fifo_read_data,
  // AXI read address and data
  output logic [`SD_ADMA_ADDR_W-1:0]  araddr,
  output logic [7:0]                  arlen,
  output logic [2:0]                  arsize,
  output logic [1:0]                  arburst,
  output logic                        arvalid,
  input  logic                        arready,
  input  logic [`SD_ADMA_DATA_W-1:0]  rdata,
  input  logic                        rvalid,
  input  logic                        rlast,
  output logic                        rready,
  // AXI write address and data
  output logic [`SD_ADMA_ADDR_W-1:0]  awaddr,
  output logic [7:0]                  awlen,
  output logic [2:0]                  awsize,
  output logic [1:0]                  awburst,
  output logic                        awvalid,
  input  logic                        awready,
  output logic [`SD_ADMA_DATA_W-1:0]  wdata,
  output logic                        wvalid,
  input  logic                        wready,
  output logic                        wlast
);

  import sd_adma_pkg::*;

  logic                       fetch_start;
  logic                       read_start;
  logic                       write_start;
  logic [`SD_ADMA_ADDR_W-1:0] pointer;
  logic [`SD_ADMA_ADDR_W-1:0] data_address;
  logic [`SD_ADMA_COUNT_W-1:0] word_total;
  logic                       read_busy;
  logic                       write_busy;
  logic [`SD_ADMA_COUNT_W-1:0] fill_count;
  adma_descriptor_t           descriptor;

  // Port names match the internal nets one to one
  fill_monitor     fill_monitor_i (.*);
  adma_sequencer   adma_sequencer_i (.*);
  axi_read_master  axi_read_master_i (.*);
  axi_write_master axi_write_master_i (.*);

endmodule

/* verif/tb_sd_adma.sv */
`timescale 1ns/1ns
`include "sd_adma_config.svh"

module tb_sd_adma;

  import sd_adma_pkg::*;

  localparam int ADDR_W      = `SD_ADMA_ADDR_W;
  localparam int DATA_W      = `SD_ADMA_DATA_W;
  localparam int COUNT_W     = `SD_ADMA_COUNT_W;
  localparam int BURST_BEATS = `SD_ADMA_BURST_BEATS;
  localparam int BURST_BYTES = `SD_ADMA_BURST_BEATS * `SD_ADMA_DATA_W / 8;
  localparam int MEM_WORDS   = 1024;
  localparam int ROWS        = 5;
  localparam int MAX_DESC    = 3;
  localparam int WAIT_LIMIT  = 2000;
  localparam logic [1:0] IRQ_DONE = 2'b01 << `SD_ADMA_IRQ_COMPLETE;
  localparam logic [1:0] IRQ_ERR  = 2'b01 << `SD_ADMA_IRQ_ERROR;
  localparam logic [1:0] ACT_NOP  = 2'b00;
  // AXI encodings for 4-byte beats and incrementing bursts
  localparam logic [2:0] AXI_SIZE_4B    = 3'b010;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  logic               clock             = 1'b0;
  logic               reset             = 1'b0;
  logic               dma_enable        = 1'b0;
  logic               direction_to_card = 1'b0;
  logic               cmd_complete      = 1'b0;
  logic               data_present      = 1'b0;
  logic [ADDR_W-1:0]  descriptor_base   = '0;
  logic               xfer_complete     = 1'b0;
  logic               block_gap_request = 1'b0;
  logic               int_clear         = 1'b0;
  logic               is_we_en          = 1'b0;
  logic [DATA_W-1:0]  fifo_read_data    = '0;
  logic               arready           = 1'b0;
  logic [DATA_W-1:0]  rdata             = '0;
  logic               rvalid            = 1'b0;
  logic               rlast             = 1'b0;
  logic               awready           = 1'b0;
  logic               wready            = 1'b0;
  logic [1:0]         dma_interrupts;
  logic               fifo_reset;
  logic               fifo_write;
  logic [DATA_W-1:0]  fifo_write_data;
  logic               fifo_read;
  logic [ADDR_W-1:0]  araddr;
  logic [7:0]         arlen;
  logic [2:0]         arsize;
  logic [1:0]         arburst;
  logic               arvalid;
  logic               rready;
  logic [ADDR_W-1:0]  awaddr;
  logic [7:0]         awlen;
  logic [2:0]         awsize;
  logic [1:0]         awburst;
  logic               awvalid;
  logic [DATA_W-1:0]  wdata;
  logic               wvalid;
  logic               wlast;

  sd_adma_top dut_i (.*);

  always #4 clock = ~clock;

  // Stimulus table
  logic [ADDR_W-1:0]  row_base      [ROWS];
  logic               row_to_card   [ROWS];
  logic               row_gap       [ROWS];
  logic [1:0]         row_irq       [ROWS];
  logic [COUNT_W-1:0] row_words     [ROWS];
  logic [ADDR_W-1:0]  row_data_addr [ROWS];
  int                 row_ndesc     [ROWS];
  int                 row_nfetch    [ROWS];
  logic [ADDR_W-1:0]  row_desc_at   [ROWS][MAX_DESC];
  adma_descriptor_t   row_desc      [ROWS][MAX_DESC];
  logic [ADDR_W-1:0]  row_fetch     [ROWS][MAX_DESC];

  // Memory, bus logs and the card-side FIFO model
  integer             seed = 53991;
  logic [DATA_W-1:0]  mem [MEM_WORDS];
  logic [ADDR_W-1:0]  rq_addr [$];
  logic [7:0]         rq_len [$];
  logic [ADDR_W-1:0]  fetch_log [$];
  logic [ADDR_W-1:0]  data_ar_log [$];
  logic [ADDR_W-1:0]  aw_log [$];
  logic [DATA_W-1:0]  w_log [$];
  logic [DATA_W-1:0]  card_log [$];
  logic [DATA_W-1:0]  pushed_log [$];
  logic [DATA_W-1:0]  fifo_q [$];
  logic [7:0]         r_beat = '0;
  logic [7:0]         w_beat = '0;
  int                 ser_words = 0;
  int                 ser_left = 0;
  logic [DATA_W-1:0]  ser_word = 32'hca00_0000;
  logic               ar_hs, r_hs, aw_hs, w_hs, rd_hs, wr_hs, fr_hs;
  logic [ADDR_W-1:0]  ar_addr_s, aw_addr_s;
  logic [7:0]         ar_len_s, aw_len_s;
  logic [2:0]         ar_size_s, aw_size_s;
  logic [1:0]         ar_burst_s, aw_burst_s;
  logic [DATA_W-1:0]  wdata_s, fw_data_s;
  logic               wlast_s;

  //////////////////////////////
  // Failure reporting and checks
  //////////////////////////////
  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s at t=%0t", what, $time);
    stop_run();
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                            input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_address(input string name, input logic [ADDR_W-1:0] expected,
                               input logic [ADDR_W-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_irq(input string name, input logic [1:0] expected,
                           input logic [1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input logic [COUNT_W-1:0] expected,
                             input logic [COUNT_W-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_idle_outputs();
    check_flag("arvalid", 1'b0, arvalid);
    check_flag("awvalid", 1'b0, awvalid);
    check_flag("wvalid", 1'b0, wvalid);
    check_flag("wlast", 1'b0, wlast);
    check_flag("rready", 1'b0, rready);
    check_flag("fifo_write", 1'b0, fifo_write);
    check_flag("fifo_read", 1'b0, fifo_read);
    check_flag("fifo_reset", 1'b0, fifo_reset);
    check_irq("dma_interrupts", 2'b00, dma_interrupts);
  endtask

  // Fill value tied to the full byte address
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a00_00a5;
  endfunction

  function automatic logic [9:0] word_index(input logic [ADDR_W-1:0] addr);
    return addr[11:2];
  endfunction

  function automatic adma_descriptor_t make_desc(input logic [ADDR_W-1:0] address,
                                                 input logic [15:0] length,
                                                 input logic [1:0] act,
                                                 input logic end_flag,
                                                 input logic valid);
    adma_descriptor_t d;
    d = '0;
    d.fields.address  = address;
    d.fields.length   = length;
    d.fields.act      = act;
    d.fields.end_flag = end_flag;
    d.fields.valid    = valid;
    return d;
  endfunction

  //////////////////////////////
  // Table setup
  //////////////////////////////
  task automatic set_row(input int r, input logic [ADDR_W-1:0] base, input logic to_card,
                         input logic gap, input logic [1:0] irq,
                         input logic [COUNT_W-1:0] words,
                         input logic [ADDR_W-1:0] data_addr);
    row_base[r]      = base;
    row_to_card[r]   = to_card;
    row_gap[r]       = gap;
    row_irq[r]       = irq;
    row_words[r]     = words;
    row_data_addr[r] = data_addr;
    row_ndesc[r]     = 0;
    row_nfetch[r]    = 0;
  endtask

  task automatic add_desc(input int r, input logic [ADDR_W-1:0] at, input adma_descriptor_t d);
    row_desc_at[r][row_ndesc[r]] = at;
    row_desc[r][row_ndesc[r]]    = d;
    row_ndesc[r]++;
  endtask

  task automatic expect_fetch(input int r, input logic [ADDR_W-1:0] addr);
    row_fetch[r][row_nfetch[r]] = addr;
    row_nfetch[r]++;
  endtask

  task automatic load_table();
    // Card to memory with 128 bytes in two bursts
    set_row(0, 32'h100, 1'b0, 1'b0, IRQ_DONE, 17'd32, 32'h400);
    add_desc(0, 32'h100, make_desc(32'h400, 16'd128, `SD_ADMA_ACT_TRAN, 1'b1, 1'b1));
    expect_fetch(0, 32'h100);
    // Memory to card in one burst
    set_row(1, 32'h140, 1'b1, 1'b0, IRQ_DONE, 17'd16, 32'h500);
    add_desc(1, 32'h140, make_desc(32'h500, 16'd64, `SD_ADMA_ACT_TRAN, 1'b1, 1'b1));
    expect_fetch(1, 32'h140);
    // Nop then link then the data line
    set_row(2, 32'h180, 1'b1, 1'b0, IRQ_DONE, 17'd16, 32'h600);
    add_desc(2, 32'h180, make_desc(32'h0, 16'd0, ACT_NOP, 1'b0, 1'b1));
    add_desc(2, 32'h188, make_desc(32'h1c0, 16'd0, `SD_ADMA_ACT_LINK, 1'b0, 1'b1));
    add_desc(2, 32'h1c0, make_desc(32'h600, 16'd64, `SD_ADMA_ACT_TRAN, 1'b1, 1'b1));
    expect_fetch(2, 32'h180);
    expect_fetch(2, 32'h188);
    expect_fetch(2, 32'h1c0);
    // Valid bit clear
    set_row(3, 32'h200, 1'b0, 1'b0, IRQ_ERR, 17'd0, 32'h0);
    add_desc(3, 32'h200, make_desc(32'h700, 16'd64, `SD_ADMA_ACT_TRAN, 1'b1, 1'b0));
    expect_fetch(3, 32'h200);
    // Block gap stop leaves the second line untouched
    set_row(4, 32'h240, 1'b1, 1'b1, IRQ_DONE, 17'd16, 32'h700);
    add_desc(4, 32'h240, make_desc(32'h700, 16'd64, `SD_ADMA_ACT_TRAN, 1'b0, 1'b1));
    add_desc(4, 32'h248, make_desc(32'h740, 16'd64, `SD_ADMA_ACT_TRAN, 1'b1, 1'b1));
    expect_fetch(4, 32'h240);
  endtask

  //////////////////////////////
  // AXI memory, FIFO and serializer
  //////////////////////////////
  always begin
    // Handshakes sampled mid-cycle and acted on after the edge
    @(negedge clock);
    ar_hs      = arvalid && arready;
    r_hs       = rvalid && rready;
    aw_hs      = awvalid && awready;
    w_hs       = wvalid && wready;
    rd_hs      = fifo_read;
    wr_hs      = fifo_write;
    fr_hs      = fifo_reset;
    ar_addr_s  = araddr;
    ar_len_s   = arlen;
    ar_size_s  = arsize;
    ar_burst_s = arburst;
    aw_addr_s  = awaddr;
    aw_len_s   = awlen;
    aw_size_s  = awsize;
    aw_burst_s = awburst;
    wdata_s    = wdata;
    wlast_s    = wlast;
    fw_data_s  = fifo_write_data;
    @(posedge clock);
    #1;
    if (ar_hs) begin
      check_count("arsize", COUNT_W'(AXI_SIZE_4B), COUNT_W'(ar_size_s));
      check_count("arburst", COUNT_W'(AXI_BURST_INCR), COUNT_W'(ar_burst_s));
      if (ar_len_s == 8'(`SD_ADMA_DESC_BEATS - 1)) begin
        fetch_log.push_back(ar_addr_s);
      end else begin
        check_count("arlen", COUNT_W'(BURST_BEATS - 1), COUNT_W'(ar_len_s));
        data_ar_log.push_back(ar_addr_s);
      end
      rq_addr.push_back(ar_addr_s);
      rq_len.push_back(ar_len_s);
    end
    if (r_hs) begin
      if (r_beat == rq_len[0]) begin
        void'(rq_addr.pop_front());
        void'(rq_len.pop_front());
        r_beat = '0;
      end else begin
        r_beat = r_beat + 8'd1;
      end
    end
    // A raised rvalid stays until taken
    if (!rvalid || r_hs) begin
      if (rq_addr.size() > 0 && (($random(seed) & 3) != 0)) begin
        rvalid = 1'b1;
        rdata  = mem[word_index(rq_addr[0] + (ADDR_W'(r_beat) << 2))];
        rlast  = (r_beat == rq_len[0]);
      end else begin
        rvalid = 1'b0;
        rlast  = 1'b0;
      end
    end
    arready = (($random(seed) & 3) != 0);
    if (aw_hs) begin
      check_count("awlen", COUNT_W'(BURST_BEATS - 1), COUNT_W'(aw_len_s));
      check_count("awsize", COUNT_W'(AXI_SIZE_4B), COUNT_W'(aw_size_s));
      check_count("awburst", COUNT_W'(AXI_BURST_INCR), COUNT_W'(aw_burst_s));
      aw_log.push_back(aw_addr_s);
      w_beat = '0;
    end
    if (w_hs) begin
      check_flag("wlast", w_beat == 8'(BURST_BEATS - 1), wlast_s);
      w_log.push_back(wdata_s);
      w_beat = w_beat + 8'd1;
    end
    awready = (($random(seed) & 3) != 0);
    wready  = (($random(seed) & 3) != 0);
    if (wr_hs) begin
      card_log.push_back(fw_data_s);
    end
    if (fr_hs) begin
      fifo_q.delete();
      ser_left = ser_words;
    end
    if (rd_hs) begin
      void'(fifo_q.pop_front());
    end
    // Serializer writes one word per enable pulse
    if (is_we_en) begin
      is_we_en = 1'b0;
    end else if (ser_left > 0 && (($random(seed) & 1) != 0)) begin
      fifo_q.push_back(ser_word);
      pushed_log.push_back(ser_word);
      ser_word = ser_word + 32'd1;
      ser_left = ser_left - 1;
      is_we_en = 1'b1;
    end
    fifo_read_data = (fifo_q.size() > 0) ? fifo_q[0] : '0;
  end

  //////////////////////////////
  // Row execution
  //////////////////////////////
  task automatic check_data(input int r);
    int bursts;
    bursts = int'(row_words[r]) / BURST_BEATS;
    if (row_to_card[r]) begin
      check_count("write bursts", '0, COUNT_W'(aw_log.size()));
      check_count("read bursts", COUNT_W'(bursts), COUNT_W'(data_ar_log.size()));
      check_count("fifo_write words", row_words[r], COUNT_W'(card_log.size()));
      for (int k = 0; k < bursts; k++) begin
        check_address("araddr", row_data_addr[r] + ADDR_W'(k * BURST_BYTES), data_ar_log[k]);
      end
      for (int k = 0; k < int'(row_words[r]); k++) begin
        check_word("fifo_write_data", fill_word(row_data_addr[r] + ADDR_W'(k * 4)),
                   card_log[k]);
      end
    end else begin
      check_count("read bursts", '0, COUNT_W'(data_ar_log.size()));
      check_count("fifo_write words", '0, COUNT_W'(card_log.size()));
      check_count("write bursts", COUNT_W'(bursts), COUNT_W'(aw_log.size()));
      check_count("wdata words", row_words[r], COUNT_W'(w_log.size()));
      for (int k = 0; k < bursts; k++) begin
        check_address("awaddr", row_data_addr[r] + ADDR_W'(k * BURST_BYTES), aw_log[k]);
      end
      for (int k = 0; k < int'(row_words[r]); k++) begin
        check_word("wdata", pushed_log[k], w_log[k]);
      end
    end
  endtask

  task automatic run_row(input int r);
    int n;
    for (int k = 0; k < row_ndesc[r]; k++) begin
      mem[word_index(row_desc_at[r][k])]     = row_desc[r][k].beats[0];
      mem[word_index(row_desc_at[r][k] + 4)] = row_desc[r][k].beats[1];
    end
    fetch_log.delete();
    data_ar_log.delete();
    aw_log.delete();
    w_log.delete();
    card_log.delete();
    pushed_log.delete();
    ser_words         = row_to_card[r] ? 0 : int'(row_words[r]);
    direction_to_card = row_to_card[r];
    block_gap_request = row_gap[r];
    descriptor_base   = row_base[r];
    dma_enable        = 1'b1;
    cmd_complete      = 1'b1;
    data_present      = 1'b1;
    @(posedge clock);
    #1;
    dma_enable   = 1'b0;
    cmd_complete = 1'b0;
    data_present = 1'b0;
    n = 0;
    while (!arvalid) begin
      if (n == 3) begin
        report_timeout("arvalid within 3 cycles of the start");
      end
      @(posedge clock);
      #1;
      n++;
    end
    n = 0;
    while (w_log.size() + card_log.size() < int'(row_words[r])) begin
      if (n == WAIT_LIMIT) begin
        report_timeout("the data words of the transfer");
      end
      @(posedge clock);
      #1;
      n++;
    end
    // Completion must hold off until the card side reports the end
    repeat (8) @(posedge clock);
    #1;
    if (row_irq[r] == IRQ_DONE) begin
      check_irq("dma_interrupts", 2'b00, dma_interrupts);
    end
    xfer_complete = 1'b1;
    n = 0;
    while (dma_interrupts == 2'b00) begin
      if (n == WAIT_LIMIT) begin
        report_timeout("a DMA interrupt");
      end
      @(posedge clock);
      #1;
      n++;
    end
    check_irq("dma_interrupts", row_irq[r], dma_interrupts);
    repeat (8) @(posedge clock);
    #1;
    check_count("descriptor fetches", COUNT_W'(row_nfetch[r]), COUNT_W'(fetch_log.size()));
    for (int k = 0; k < row_nfetch[r]; k++) begin
      check_address("araddr", row_fetch[r][k], fetch_log[k]);
    end
    check_data(r);
    xfer_complete     = 1'b0;
    block_gap_request = 1'b0;
    int_clear         = 1'b1;
    @(posedge clock);
    #1;
    int_clear = 1'b0;
    check_irq("dma_interrupts", 2'b00, dma_interrupts);
  endtask

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(ADDR_W'(i * 4));
    end
    load_table();
    repeat (2) @(posedge clock);
    #1;
    check_idle_outputs();
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b1;
    @(posedge clock);
    #1;
    check_idle_outputs();
    for (int r = 0; r < ROWS; r++) begin
      run_row(r);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

/* sd_adma.f */
+incdir+include
source/sd_adma_pkg.sv
source/fill_monitor.sv
source/adma_sequencer.sv
source/axi_read_master.sv
source/axi_write_master.sv
source/sd_adma_top.sv
verif/tb_sd_adma.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sd_adma
FILELIST  ?= sd_adma.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
